// ==== src/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

//////////////////////////////////////////////////
// btb geometry
//////////////////////////////////////////////////
`define BTB_ENTRIES     512                          // total entries, direct mapped
`define BTB_BANKS       4                            // identical banks, picked by low index bits
`define BTB_TAG_BITS    7                            // pc bits above the index

// derived widths
`define BTB_INDEX_BITS  ($clog2(`BTB_ENTRIES))       // 9, pc[10:2]
`define BTB_BANK_BITS   ($clog2(`BTB_BANKS))         // 2, low index bits
`define BTB_ROW_BITS    (`BTB_INDEX_BITS - `BTB_BANK_BITS)
`define BTB_ROWS        (`BTB_ENTRIES / `BTB_BANKS)  // rows per bank

//////////////////////////////////////////////////
// fetch
//////////////////////////////////////////////////
`define PC_RESET        32'h0                        // first fetch address

`endif

// ==== src/fetch_pkg.sv ====
`default_nettype none

`include "fetch_cfg.svh"

package fetch_pkg;

    //////////////////////////////////////////////////
    // btb lookup / update / response
    //////////////////////////////////////////////////

    // fields of the current fetch pc
    typedef struct packed {
        logic [`BTB_BANK_BITS-1:0] bank;   // which bank owns the entry
        logic [`BTB_ROW_BITS-1:0]  row;    // row inside that bank
        logic [`BTB_TAG_BITS-1:0]  tag;    // compared against stored tag
    } btb_lookup_t;

    // training write, built from the previous fetch pc
    typedef struct packed {
        logic                      en;     // branch or jump resolved
        logic [`BTB_BANK_BITS-1:0] bank;
        logic [`BTB_ROW_BITS-1:0]  row;
        logic [`BTB_TAG_BITS-1:0]  tag;
        logic [31:0]               target; // only stored on first fill
        logic                      taken;  // becomes the strong bit
    } btb_update_t;

    typedef struct packed {
        logic        hit;                  // selected, valid, strong, tag equal
        logic [31:0] target;
    } btb_resp_t;

    //////////////////////////////////////////////////
    // decode side and prediction
    //////////////////////////////////////////////////

    // resolution of the instruction fetched last cycle
    typedef struct packed {
        logic        is_branch;
        logic        is_jump;
        logic        taken;
        logic        mispredict;           // redirect request
        logic [31:0] target;               // resolved target
    } resolve_t;

    typedef struct packed {
        logic        taken;                // predict taken this cycle
        logic [31:0] target;               // predicted next pc
    } pred_t;

    // next pc source, in priority order low to high
    typedef enum logic [1:0] {
        src_sequential = 2'd0,             // pc + 4
        src_predicted  = 2'd1,             // btb target
        src_redirect   = 2'd2              // mispredict from decode
    } pc_src_e;

endpackage

`default_nettype wire

// ==== src/btb_index_split.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_cfg.svh"

module btb_index_split (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic [31:0]        pc,        // current fetch pc
    input  wire fetch_pkg::resolve_t resolve,  // resolves the previous fetch
    output fetch_pkg::btb_lookup_t  lookup,
    output fetch_pkg::btb_update_t  update
);

    import fetch_pkg::*;

    localparam int bank_lsb = 2;                               // word address
    localparam int row_lsb  = bank_lsb + `BTB_BANK_BITS;
    localparam int tag_lsb  = bank_lsb + `BTB_INDEX_BITS;     // pc[17:11]

    logic [31:0] prev_pc;            // pc fetched one cycle ago
    btb_lookup_t prev_fields;

    // carve a pc into bank, row and tag
    function automatic btb_lookup_t split_pc(input logic [31:0] addr);
        btb_lookup_t f;
        f.bank = addr[bank_lsb +: `BTB_BANK_BITS];
        f.row  = addr[row_lsb +: `BTB_ROW_BITS];
        f.tag  = addr[tag_lsb +: `BTB_TAG_BITS];
        return f;
    endfunction

    //////////////////////////////////////////////////
    // previous fetch pc
    //////////////////////////////////////////////////
    // captured every cycle, stalls included
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_pc <= `PC_RESET;
        end else begin
            prev_pc <= pc;
        end
    end

    assign lookup      = split_pc(pc);        // same-cycle lookup
    assign prev_fields = split_pc(prev_pc);   // training address

    // training write fanned out to every bank
    always_comb begin
        update.en     = resolve.is_branch | resolve.is_jump;
        update.bank   = prev_fields.bank;
        update.row    = prev_fields.row;
        update.tag    = prev_fields.tag;
        update.target = resolve.target;
        update.taken  = resolve.taken;
    end

    // decode never flags one instruction as both kinds
    a_branch_jump_excl : assert property (@(posedge clk) disable iff (!rst_n)
        !(resolve.is_branch && resolve.is_jump));

endmodule

`default_nettype wire

// ==== src/btb_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_cfg.svh"

module btb_bank #(
    parameter int bank_id = 0                  // bank number this slice answers to
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire fetch_pkg::btb_lookup_t lookup,
    input  wire fetch_pkg::btb_update_t update,
    output fetch_pkg::btb_resp_t       resp
);

    localparam int rows = `BTB_ROWS;           // 128 per bank

    localparam logic [`BTB_BANK_BITS-1:0] my_bank = bank_id[`BTB_BANK_BITS-1:0];

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////
    logic [`BTB_TAG_BITS-1:0] tag_mem    [rows];   // tag per row
    logic [31:0]              target_mem [rows];   // branch target per row
    logic [rows-1:0]          valid_q;             // row has been filled
    logic [rows-1:0]          strong_q;            // last outcome was taken

    logic                     lookup_sel;          // lookup belongs to this bank
    logic                     wr_sel;              // training write belongs to this bank
    logic                     tag_eq;

    assign lookup_sel = (lookup.bank == my_bank);
    assign wr_sel     = update.en && (update.bank == my_bank);

    // fill tag and target only while the row is still empty
    always_ff @(posedge clk) begin
        if (wr_sel && !valid_q[update.row]) begin
            tag_mem[update.row]    <= update.tag;
            target_mem[update.row] <= update.target;
        end
    end

    //////////////////////////////////////////////////
    // valid and strong bits
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= '0;                        // everything empty
            strong_q <= '0;                        // nothing predicted
        end else if (wr_sel) begin
            valid_q[update.row]  <= 1'b1;          // sticky until reset
            strong_q[update.row] <= update.taken;  // follows the outcome
        end
    end

    //////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////
    assign tag_eq = (tag_mem[lookup.row] == lookup.tag);

    always_comb begin
        resp.hit    = lookup_sel
                   && valid_q[lookup.row]
                   && strong_q[lookup.row]
                   && tag_eq;
        resp.target = target_mem[lookup.row];      // don't care unless hit
    end

    // retraining a filled row leaves its target alone
    a_target_kept : assert property (@(posedge clk) disable iff (!rst_n)
        (wr_sel && valid_q[update.row])
        |=> (target_mem[$past(update.row)] == $past(target_mem[update.row])));

endmodule

`default_nettype wire

// ==== src/btb_hit_merge.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_cfg.svh"

module btb_hit_merge (
    input  wire fetch_pkg::btb_lookup_t                 lookup,
    input  wire fetch_pkg::btb_resp_t [`BTB_BANKS-1:0]  resp,        // one per bank
    input  wire logic                                   predict_off, // force pc + 4
    output fetch_pkg::pred_t                            pred
);

    import fetch_pkg::*;

    btb_resp_t             sel;       // response of the addressed bank
    logic [`BTB_BANKS-1:0] hit_vec;   // raw hit flags, one per bank

    //////////////////////////////////////////////////
    // bank select
    //////////////////////////////////////////////////
    assign sel = resp[lookup.bank];

    always_comb begin
        pred.taken  = sel.hit && !predict_off;   // predictor off wins
        pred.target = sel.target;
    end

    //////////////////////////////////////////////////
    // sanity
    //////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < `BTB_BANKS; i++) begin
            hit_vec[i] = resp[i].hit;
        end
    end

    // banks decode lookup.bank on their own, so at most one may claim it
    always_comb begin
        a_single_hit : assert ($onehot0(hit_vec));
    end

endmodule

`default_nettype wire

// ==== src/pc_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_cfg.svh"

module pc_gen (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                pc_enable,   // low holds the pc
    input  wire fetch_pkg::pred_t    pred,        // from the hit merger
    input  wire fetch_pkg::resolve_t resolve,     // redirect from decode
    output logic [31:0]              pc
);

    import fetch_pkg::*;

    pc_src_e     pc_src;       // where next_pc comes from
    logic [31:0] pc_plus_4;
    logic [31:0] next_pc;

    //////////////////////////////////////////////////
    // source select
    //////////////////////////////////////////////////
    // redirect > prediction > sequential
    always_comb begin
        if (resolve.mispredict) begin
            pc_src = src_redirect;
        end else if (pred.taken) begin
            pc_src = src_predicted;
        end else begin
            pc_src = src_sequential;
        end
    end

    assign pc_plus_4 = pc + 32'd4;

    always_comb begin
        case (pc_src)
            src_redirect:  next_pc = resolve.target;  // fix up after mispredict
            src_predicted: next_pc = pred.target;     // btb hit
            default:       next_pc = pc_plus_4;       // fall through
        endcase
    end

    //////////////////////////////////////////////////
    // fetch pc register
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `PC_RESET;
        end else if (pc_enable) begin
            pc <= next_pc;             // stall just holds
        end
    end

    // instructions are 32 bit, fetch never leaves word alignment
    a_pc_aligned : assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== src/fetch_predict_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_predict_top (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                pc_enable,     // low stalls fetch
    input  wire logic                predict_off,   // sequential only
    input  wire fetch_pkg::resolve_t resolve,       // outcome of last fetch
    output logic [31:0]              pc,
    output logic                     predict_taken
);

    import fetch_pkg::*;

    btb_lookup_t                  lookup;     // fetch pc fields, to all banks
    btb_update_t                  update;     // training write, to all banks
    btb_resp_t [`BTB_BANKS-1:0]   resp_bus;   // per bank responses
    pred_t                        pred;

    //////////////////////////////////////////////////
    // index split
    //////////////////////////////////////////////////
    btb_index_split index_split_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .pc      (pc),
        .resolve (resolve),
        .lookup  (lookup),
        .update  (update)
    );

    //////////////////////////////////////////////////
    // btb banks
    //////////////////////////////////////////////////
    for (genvar g = 0; g < `BTB_BANKS; g++) begin : g_bank
        btb_bank #(
            .bank_id (g)
        ) bank_inst (
            .clk     (clk),
            .rst_n   (rst_n),
            .lookup  (lookup),
            .update  (update),
            .resp    (resp_bus[g])
        );
    end

    //////////////////////////////////////////////////
    // merge and next pc
    //////////////////////////////////////////////////
    btb_hit_merge hit_merge_inst (
        .lookup      (lookup),
        .resp        (resp_bus),
        .predict_off (predict_off),
        .pred        (pred)
    );

    pc_gen pc_gen_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .pc_enable (pc_enable),
        .pred      (pred),
        .resolve   (resolve),
        .pc        (pc)
    );

    assign predict_taken = pred.taken;   // exported for the fetch/decode register

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int half_period  = 2,     // 4 ns clock
    parameter int reset_cycles = 4      // rising edges with reset low
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // active low, released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== testbench/fetch_predict_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_predict_tb;

    import fetch_pkg::*;

    localparam int clk_period      = 4;
    localparam int rand_cycles     = 2000;
    localparam int directed_cycles = 100;     // generous count for tests 1 to 5
    localparam int watchdog_ns     = 20 * (rand_cycles + directed_cycles) * clk_period + 400;
    localparam int idx_bits        = `BTB_INDEX_BITS;

    logic        clk;
    logic        rst_n;
    logic        pc_enable;
    logic        predict_off;
    resolve_t    resolve;
    logic [31:0] pc;
    logic        predict_taken;

    int n_tests  = 0;
    int n_checks = 0;
    int n_errors = 0;

    // reference state with one slot per direct mapped entry
    logic                     m_valid  [`BTB_ENTRIES];
    logic                     m_strong [`BTB_ENTRIES];
    logic [`BTB_TAG_BITS-1:0] m_tag    [`BTB_ENTRIES];
    logic [31:0]              m_target [`BTB_ENTRIES];
    logic [31:0]              m_pc;     // expected fetch pc
    logic [31:0]              m_prev;   // expected previous fetch pc

    tb_clock_gen clock_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fetch_predict_top fetch_predict_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .pc_enable     (pc_enable),
        .predict_off   (predict_off),
        .resolve       (resolve),
        .pc            (pc),
        .predict_taken (predict_taken)
    );

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    function automatic void clear_model();
        for (int i = 0; i < `BTB_ENTRIES; i++) begin
            m_valid[i]  = 1'b0;
            m_strong[i] = 1'b0;
        end
        m_pc   = `PC_RESET;
        m_prev = `PC_RESET;
    endfunction

    // index is pc[10:2] and the tag is the 7 bits above
    function automatic pred_t predict_ref(input logic [31:0] addr, input logic off);
        pred_t                 p;
        logic [idx_bits-1:0]   idx;
        logic [`BTB_TAG_BITS-1:0] tag;
        idx      = addr[idx_bits+1:2];
        tag      = addr[idx_bits+2 +: `BTB_TAG_BITS];
        p.taken  = m_valid[idx] && m_strong[idx] && (m_tag[idx] == tag) && !off;
        p.target = m_target[idx];
        return p;
    endfunction

    // state change over one clock edge with the fetch stage priority
    function automatic void step_model(input logic en, input resolve_t r, input logic off);
        pred_t               p;
        pc_src_e             src;
        logic [31:0]         nxt;
        logic [idx_bits-1:0] idx;
        p = predict_ref(m_pc, off);          // lookup sees the old entry
        if (r.mispredict) src = src_redirect;
        else if (p.taken) src = src_predicted;
        else src = src_sequential;
        case (src)
            src_redirect:  nxt = r.target;
            src_predicted: nxt = p.target;
            default:       nxt = m_pc + 32'd4;
        endcase
        if (r.is_branch || r.is_jump) begin  // train the previous fetch pc
            idx = m_prev[idx_bits+1:2];
            if (!m_valid[idx]) begin         // first fill only
                m_tag[idx]    = m_prev[idx_bits+2 +: `BTB_TAG_BITS];
                m_target[idx] = r.target;
            end
            m_valid[idx]  = 1'b1;
            m_strong[idx] = r.taken;
        end
        m_prev = m_pc;                       // even while stalled
        if (en) m_pc = nxt;
    endfunction

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////
    task automatic check_pc(input logic [31:0] got, input logic [31:0] exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error %0t ns: %s pc got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_pred(input logic got, input logic exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error %0t ns: %s predict_taken got %b expected %b", $time, what, got, exp);
        end
    endtask

    // compare in mid cycle between drive edges
    always @(negedge clk) begin : model_compare
        pred_t exp_pred;
        if (rst_n !== 1'b1) begin
            clear_model();
        end else begin
            exp_pred = predict_ref(m_pc, predict_off);
            check_pc(pc, m_pc, "model");
            check_pred(predict_taken, exp_pred.taken, "model");
            step_model(pc_enable, resolve, predict_off);
        end
    end

    //////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////
    function automatic resolve_t make_resolve(input logic br, input logic jmp, input logic tk,
                                              input logic mis, input logic [31:0] tgt);
        resolve_t r;
        r.is_branch  = br;
        r.is_jump    = jmp;
        r.taken      = tk;
        r.mispredict = mis;
        r.target     = tgt;
        return r;
    endfunction

    task automatic drive_cycle(input logic en, input resolve_t r, input logic off);
        @(posedge clk);
        pc_enable   <= en;
        resolve     <= r;
        predict_off <= off;
    endtask

    task automatic go_to(input logic [31:0] addr, input logic off);
        drive_cycle(1'b1, make_resolve(1'b0, 1'b0, 1'b0, 1'b1, addr), off);  // redirect
    endtask

    // fetch addr, then resolve it as a branch one cycle later
    task automatic train_entry(input logic [31:0] addr, input logic [31:0] tgt, input logic tk);
        go_to(addr, 1'b0);
        drive_cycle(1'b1, '0, 1'b0);
        drive_cycle(1'b1, make_resolve(1'b1, 1'b0, tk, 1'b0, tgt), 1'b0);
    endtask

    task automatic expect_now(input logic [31:0] exp_pc, input logic exp_taken);
        @(negedge clk);
        check_pc(pc, exp_pc, "directed");
        check_pred(predict_taken, exp_taken, "directed");
    endtask

    task automatic report_test(input string name, input int errs_before);
        n_tests++;
        if (n_errors == errs_before) $display("test %0d %s: ok", n_tests, name);
        else $display("test %0d %s: %0d mismatches", n_tests, name, n_errors - errs_before);
    endtask

    //////////////////////////////////////////////////
    // watchdog
    //////////////////////////////////////////////////
    initial begin
        #(watchdog_ns);
        $display("timeout: the run did not finish within %0d ns", watchdog_ns);
        $display(">>> FAIL");
        $finish;
    end

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////
    initial begin
        int          mark;
        logic [31:0] e;
        resolve_t    r;
        logic        off_q;
        int unsigned roll;

        void'($urandom(32'h67bd));
        pc_enable   <= 1'b0;
        predict_off <= 1'b0;
        resolve     <= '0;
        off_q = 1'b0;
        wait (rst_n === 1'b1);

        // test 1 covers reset value, sequential fetch and stall
        mark = n_errors;
        e = `PC_RESET;
        drive_cycle(1'b0, '0, 1'b0);
        expect_now(e, 1'b0);
        repeat (4) begin
            drive_cycle(1'b1, '0, 1'b0);
            expect_now(e, 1'b0);            // previous cycle's result
            e = e + 32'd4;
        end
        drive_cycle(1'b0, '0, 1'b0);
        expect_now(e, 1'b0);
        drive_cycle(1'b0, '0, 1'b0);
        expect_now(e, 1'b0);                // still held
        report_test("reset and sequential fetch", mark);

        // test 2 has a redirect beat a live prediction
        mark = n_errors;
        train_entry(32'h500, 32'h600, 1'b1);
        go_to(32'h500, 1'b0);
        drive_cycle(1'b1, make_resolve(1'b0, 1'b0, 1'b0, 1'b1, 32'h700), 1'b0);
        expect_now(32'h500, 1'b1);
        drive_cycle(1'b1, '0, 1'b0);
        expect_now(32'h700, 1'b0);
        report_test("mispredict redirect", mark);

        // test 3 trains taken and then not taken
        mark = n_errors;
        train_entry(32'h100, 32'h200, 1'b1);
        go_to(32'h100, 1'b0);
        drive_cycle(1'b1, '0, 1'b0);
        expect_now(32'h100, 1'b1);
        drive_cycle(1'b1, '0, 1'b0);
        expect_now(32'h200, 1'b0);
        train_entry(32'h100, 32'h200, 1'b0);
        go_to(32'h100, 1'b0);
        drive_cycle(1'b1, '0, 1'b0);
        expect_now(32'h100, 1'b0);
        drive_cycle(1'b1, '0, 1'b0);
        expect_now(32'h104, 1'b0);
        report_test("train and untrain", mark);

        // test 4 shows a valid entry keeping its first target
        mark = n_errors;
        train_entry(32'h100, 32'h300, 1'b1);
        go_to(32'h100, 1'b0);
        drive_cycle(1'b1, '0, 1'b0);
        expect_now(32'h100, 1'b1);
        drive_cycle(1'b1, '0, 1'b0);
        expect_now(32'h200, 1'b0);
        report_test("fill only when invalid", mark);

        // test 5 aliases with another tag and then turns the predictor off
        mark = n_errors;
        go_to(32'h900, 1'b0);                // same index as 0x100 with tag 1
        drive_cycle(1'b1, '0, 1'b0);
        expect_now(32'h900, 1'b0);
        drive_cycle(1'b1, '0, 1'b0);
        expect_now(32'h904, 1'b0);
        go_to(32'h100, 1'b1);
        drive_cycle(1'b1, '0, 1'b1);
        expect_now(32'h100, 1'b0);
        drive_cycle(1'b1, '0, 1'b1);
        expect_now(32'h104, 1'b0);
        drive_cycle(1'b1, '0, 1'b0);
        report_test("tag miss and predictor off", mark);

        // test 6 is random traffic checked by the model every cycle
        mark = n_errors;
        repeat (rand_cycles) begin
            r = '0;
            roll = $urandom % 100;
            if (roll < 25) begin
                r.is_branch = 1'b1;
                r.taken     = ($urandom % 2) != 0;
            end else if (roll < 35) begin
                r.is_jump = 1'b1;
                r.taken   = 1'b1;                     // jumps always go
            end
            r.target     = $urandom & 32'h0000_0ffc;   // word aligned targets in a small window
            r.mispredict = ($urandom % 100) < 15;
            if (($urandom % 100) < 3) off_q = !off_q;
            drive_cycle(($urandom % 10) != 0, r, off_q);
        end
        drive_cycle(1'b1, '0, 1'b0);
        drive_cycle(1'b1, '0, 1'b0);
        @(negedge clk);
        report_test("random sequences", mark);

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+src
src/fetch_pkg.sv
src/btb_index_split.sv
src/btb_bank.sv
src/btb_hit_merge.sv
src/pc_gen.sv
src/fetch_predict_top.sv
testbench/tb_clock_gen.sv
testbench/fetch_predict_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the fetch predictor testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module fetch_predict_tb \
    -f list.f

# keep the output in a variable so the result can be searched
sim_out=$(./obj_dir/Vfetch_predict_tb 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q '^>>> PASS$'; then
    exit 0
else
    exit 1
fi
